// File: hw/tcb_lite_arbiter.sv
/*
 * TCB-Lite fixed priority arbiter
 * grants one subordinate per cycle, holds the grant across locked transfers
 */
module tcb_lite_arbiter
    import tcb_lite_pkg::*;
    import tcb_lite_map_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic [SUB_IFN-1:0] sub_vld,   // request valid per subordinate
    input  logic [SUB_IFN-1:0] sub_lck,   // request lock per subordinate
    input  logic               xfer,      // granted request transferred
    output logic               gnt_vld,   // some subordinate granted
    output sub_idx_t           gnt_idx    // granted subordinate
);

    ////////////////////////////////////////
    // lock state
    ////////////////////////////////////////

    arb_state_t state;
    sub_idx_t   own;      // lock owner

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ARB_IDLE;
            own   <= '0;
        end else if (xfer) begin
            // every transfer decides the next state
            if (sub_lck[gnt_idx]) begin
                state <= ARB_LOCKED;
                own   <= gnt_idx;
            end else begin
                state <= ARB_IDLE;  // owner released lock
            end
        end
    end

    ////////////////////////////////////////
    // grant
    ////////////////////////////////////////

    always_comb begin
        gnt_vld = 1'b0;
        gnt_idx = SUB_PRI[0];
        if (state == ARB_LOCKED) begin
            // only the owner may proceed
            gnt_vld = sub_vld[own];
            gnt_idx = own;
        end else begin
            // walk from lowest priority up, last hit wins
            for (int i = SUB_IFN-1; i >= 0; i--) begin
                if (sub_vld[SUB_PRI[i]]) begin
                    gnt_vld = 1'b1;
                    gnt_idx = SUB_PRI[i];
                end
            end
        end
    end

endmodule: tcb_lite_arbiter

// File: hw/tcb_lite_decoder.sv
/*
 * TCB-Lite address decoder
 * maps each subordinate address to a manager index and a hit flag
 */
module tcb_lite_decoder
    import tcb_lite_pkg::*;
    import tcb_lite_map_pkg::*;
(
    input  tcb_adr_t [SUB_IFN-1:0] sub_adr,   // address per subordinate
    output man_idx_t [SUB_IFN-1:0] dec_idx,   // decoded manager
    output logic     [SUB_IFN-1:0] dec_hit    // address inside the map
);

    ////////////////////////////////////////
    // per subordinate decode
    ////////////////////////////////////////

    // all subordinates decoded in parallel, independent of grant
    for (genvar s = 0; s < SUB_IFN; s++) begin: gen_sub

        logic [MAN_IFN-1:0] match;  // one bit per manager region
        man_idx_t           idx;    // encoded match

        // region compare
        for (genvar m = 0; m < MAN_IFN; m++) begin: gen_man
            assign match[m] = (sub_adr[s] & MAN_MASK[m]) == MAN_BASE[m];
        end: gen_man

        // regions do not overlap, lowest index taken anyway
        always_comb begin
            idx = '0;
            for (int m = MAN_IFN-1; m >= 0; m--) begin
                if (match[m]) begin
                    idx = man_idx_t'(m);
                end
            end
        end

        assign dec_idx[s] = idx;
        assign dec_hit[s] = |match;  // low on decode miss

    end: gen_sub

endmodule: tcb_lite_decoder

// File: hw/tcb_lite_interconnect.sv
/*
 * TCB-Lite two-to-two interconnect
 * arbiter and decoder work side by side, the switch combines them
 */
module tcb_lite_interconnect
    import tcb_lite_pkg::*;
    import tcb_lite_map_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    // subordinate ports, from bus managers
    input  logic     [SUB_IFN-1:0] sub_vld,
    input  tcb_req_t [SUB_IFN-1:0] sub_req,
    output logic     [SUB_IFN-1:0] sub_rdy,
    output tcb_rsp_t [SUB_IFN-1:0] sub_rsp,
    // manager ports, to targets
    output logic     [MAN_IFN-1:0] man_vld,
    output tcb_req_t [MAN_IFN-1:0] man_req,
    input  logic     [MAN_IFN-1:0] man_rdy,
    input  tcb_rsp_t [MAN_IFN-1:0] man_rsp
);

    ////////////////////////////////////////
    // internal wires
    ////////////////////////////////////////

    logic     [SUB_IFN-1:0] sub_lck;  // lock flags for the arbiter
    tcb_adr_t [SUB_IFN-1:0] sub_adr;  // addresses for the decoder
    logic                   gnt_vld;
    sub_idx_t               gnt_idx;
    man_idx_t [SUB_IFN-1:0] dec_idx;
    logic     [SUB_IFN-1:0] dec_hit;
    logic                   xfer;     // granted transfer this cycle

    for (genvar s = 0; s < SUB_IFN; s++) begin: gen_sub
        assign sub_lck[s] = sub_req[s].lck;
        assign sub_adr[s] = sub_req[s].adr;
    end: gen_sub

    ////////////////////////////////////////
    // blocks
    ////////////////////////////////////////

    tcb_lite_arbiter i_arb (
        .clk     (clk),
        .reset   (reset),
        .sub_vld (sub_vld),
        .sub_lck (sub_lck),
        .xfer    (xfer),
        .gnt_vld (gnt_vld),
        .gnt_idx (gnt_idx)
    );

    tcb_lite_decoder i_dec (
        .sub_adr (sub_adr),
        .dec_idx (dec_idx),
        .dec_hit (dec_hit)
    );

    tcb_lite_switch i_sw (
        .clk     (clk),
        .reset   (reset),
        .gnt_vld (gnt_vld),
        .gnt_idx (gnt_idx),
        .dec_idx (dec_idx),
        .dec_hit (dec_hit),
        .sub_req (sub_req),
        .sub_rdy (sub_rdy),
        .sub_rsp (sub_rsp),
        .man_vld (man_vld),
        .man_req (man_req),
        .man_rdy (man_rdy),
        .man_rsp (man_rsp),
        .xfer    (xfer)
    );

endmodule: tcb_lite_interconnect

// File: hw/tcb_lite_map_pkg.sv
/*
 * TCB-Lite system configuration package
 * port counts, manager address map, subordinate priority
 */
package tcb_lite_map_pkg;

    import tcb_lite_pkg::*;

    ////////////////////////////////////////
    // port counts and index types
    ////////////////////////////////////////

    localparam int unsigned SUB_IFN = 2;    // subordinate ports (bus managers)
    localparam int unsigned MAN_IFN = 2;    // manager ports (targets)

    typedef logic [$clog2(SUB_IFN)-1:0] sub_idx_t;  // subordinate port index
    typedef logic [$clog2(MAN_IFN)-1:0] man_idx_t;  // manager port index

    ////////////////////////////////////////
    // address map
    ////////////////////////////////////////

    // a manager matches when (adr & MASK) == BASE
    localparam tcb_adr_t MAN_BASE [MAN_IFN] = '{
        32'h0000_0000,  // man[0] 0x0000_0000 .. 0x0000_FFFF
        32'h8000_0000   // man[1] 0x8000_0000 .. 0x8000_FFFF
    };
    localparam tcb_adr_t MAN_MASK [MAN_IFN] = '{
        32'hFFFF_0000,
        32'hFFFF_0000
    };

    // priority order, entry 0 wins
    localparam sub_idx_t SUB_PRI [SUB_IFN] = '{1'd0, 1'd1};

endpackage: tcb_lite_map_pkg

// File: hw/tcb_lite_pkg.sv
/*
 * TCB-Lite bus protocol package
 * widths, vector types, request/response structs, handshake delay
 */
package tcb_lite_pkg;

    ////////////////////////////////////////
    // bus widths and handshake timing
    ////////////////////////////////////////

    localparam int unsigned ADR = 32;       // address width
    localparam int unsigned DAT = 32;       // data width
    localparam int unsigned BYT = DAT/8;    // byte enable width, one per byte lane
    localparam int unsigned DLY = 1;        // response delay after transfer

    ////////////////////////////////////////
    // vector types
    ////////////////////////////////////////

    typedef logic [ADR-1:0] tcb_adr_t;      // byte address
    typedef logic [DAT-1:0] tcb_dat_t;      // read/write data word
    typedef logic [BYT-1:0] tcb_byt_t;      // byte enable mask

    ////////////////////////////////////////
    // request and response payloads
    ////////////////////////////////////////

    // request, valid while vld is high
    typedef struct packed {
        logic     lck;  // keep arbitration after this transfer
        logic     wen;  // write enable
        logic     ren;  // read enable
        tcb_adr_t adr;  // address
        tcb_byt_t byt;  // byte enable
        tcb_dat_t wdt;  // write data
    } tcb_req_t;

    // response, DLY cycles after transfer, lasts one cycle
    typedef struct packed {
        tcb_dat_t rdt;  // read data
        logic     err;  // bus error
    } tcb_rsp_t;

    // response given locally on a decode miss
    localparam tcb_rsp_t RSP_ERR = '{rdt: '0, err: 1'b1};

    ////////////////////////////////////////
    // arbiter FSM
    ////////////////////////////////////////

    typedef enum logic {
        ARB_IDLE,       // free grant by priority
        ARB_LOCKED      // grant held by lock owner
    } arb_state_t;

endpackage: tcb_lite_pkg

// File: hw/tcb_lite_switch.sv
/*
 * TCB-Lite request/response switch
 * forwards the granted request to the decoded manager, answers decode
 * misses with an error and returns responses to their requester
 */
module tcb_lite_switch
    import tcb_lite_pkg::*;
    import tcb_lite_map_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    // arbiter and decoder results
    input  logic                   gnt_vld,
    input  sub_idx_t               gnt_idx,
    input  man_idx_t [SUB_IFN-1:0] dec_idx,
    input  logic     [SUB_IFN-1:0] dec_hit,
    // subordinate side
    input  tcb_req_t [SUB_IFN-1:0] sub_req,
    output logic     [SUB_IFN-1:0] sub_rdy,
    output tcb_rsp_t [SUB_IFN-1:0] sub_rsp,
    // manager side
    output logic     [MAN_IFN-1:0] man_vld,
    output tcb_req_t [MAN_IFN-1:0] man_req,
    input  logic     [MAN_IFN-1:0] man_rdy,
    input  tcb_rsp_t [MAN_IFN-1:0] man_rsp,
    // transfer of the granted request
    output logic                   xfer
);

    // where a response has to go
    typedef struct packed {
        logic     vld;  // transfer happened
        sub_idx_t sub;  // requester
        man_idx_t man;  // responding manager
        logic     mis;  // decode miss, answer locally
    } rte_t;

    ////////////////////////////////////////
    // request path
    ////////////////////////////////////////

    tcb_req_t sel_req;  // granted request
    man_idx_t sel_man;  // its manager
    logic     sel_hit;  // its decode hit
    logic     sel_rdy;  // ready seen by the granted subordinate

    assign sel_req = sub_req[gnt_idx];
    assign sel_man = dec_idx[gnt_idx];
    assign sel_hit = dec_hit[gnt_idx];

    // payload goes to every manager, only vld is steered
    always_comb begin
        for (int m = 0; m < MAN_IFN; m++) begin
            man_req[m] = sel_req;
        end
    end

    always_comb begin
        man_vld = '0;
        if (gnt_vld && sel_hit) begin
            man_vld[sel_man] = 1'b1;
        end
    end

    // a miss is accepted at once
    assign sel_rdy = sel_hit ? man_rdy[sel_man] : 1'b1;

    always_comb begin
        sub_rdy = '0;
        if (gnt_vld) begin
            sub_rdy[gnt_idx] = sel_rdy;  // others wait
        end
    end

    assign xfer = gnt_vld & sel_rdy;

    ////////////////////////////////////////
    // route delay line
    ////////////////////////////////////////

    rte_t rte_d;        // route of the current transfer
    rte_t rte_q [DLY];  // one stage per response delay cycle
    rte_t rte;          // route due this cycle

    assign rte_d = '{vld: xfer, sub: gnt_idx, man: sel_man, mis: ~sel_hit};

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DLY; i++) begin
                rte_q[i] <= '0;
            end
        end else begin
            rte_q[0] <= rte_d;
            for (int i = 1; i < DLY; i++) begin
                rte_q[i] <= rte_q[i-1];
            end
        end
    end

    assign rte = rte_q[DLY-1];

    ////////////////////////////////////////
    // response path
    ////////////////////////////////////////

    always_comb begin
        sub_rsp = '0;  // idle ports see zero data, no error
        if (rte.vld) begin
            if (rte.mis) begin
                sub_rsp[rte.sub] = RSP_ERR;           // local error
            end else begin
                sub_rsp[rte.sub] = man_rsp[rte.man];  // target answer
            end
        end
    end

endmodule: tcb_lite_switch

// File: run.sh
#!/usr/bin/env bash
# build and run the interconnect simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tcb_lite_interconnect_tb \
    -f tcb_lite_interconnect.f \
    -o tb_sim

# exit status follows the testbench result
./obj_dir/tb_sim

// File: sim/tcb_lite_interconnect_chk.sv
/*
 * TCB-Lite interconnect port checker
 * bound to the top level, watches grant and routing rules on its ports
 */
module tcb_lite_interconnect_chk
    import tcb_lite_pkg::*;
    import tcb_lite_map_pkg::*;
(
    input logic                   clk,
    input logic                   reset,
    input logic     [SUB_IFN-1:0] sub_vld,
    input tcb_req_t [SUB_IFN-1:0] sub_req,
    input logic     [SUB_IFN-1:0] sub_rdy,
    input logic     [MAN_IFN-1:0] man_vld
);

    timeunit 1ns;
    timeprecision 100ps;

    // address falls in some manager region
    function automatic logic in_map(input tcb_adr_t adr);
        logic hit;
        hit = 1'b0;
        for (int m = 0; m < MAN_IFN; m++) begin
            hit = hit | ((adr & MAN_MASK[m]) == MAN_BASE[m]);
        end
        return hit;
    endfunction

    ////////////////////////////////////////
    // properties
    ////////////////////////////////////////

    a_man_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(man_vld))
        else $error("more than one manager valid");

    a_rdy_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(sub_rdy))
        else $error("more than one subordinate ready");

    a_vld_source: assert property (@(posedge clk) disable iff (reset) |man_vld |-> |sub_vld)
        else $error("manager valid without any subordinate request");

    // miss answered locally, never forwarded
    for (genvar s = 0; s < SUB_IFN; s++) begin: gen_miss
        a_miss_local: assert property (@(posedge clk) disable iff (reset)
            (sub_vld[s] && sub_rdy[s] && !in_map(sub_req[s].adr)) |-> (man_vld == '0))
            else $error("unmapped request reached a manager port");
    end: gen_miss

endmodule: tcb_lite_interconnect_chk

bind tcb_lite_interconnect tcb_lite_interconnect_chk i_chk (.*);

// File: sim/tcb_lite_interconnect_tb.sv
/*
 * TCB-Lite interconnect testbench
 * directed tests with two target memory models and a watchdog
 */
module tcb_lite_interconnect_tb
    import tcb_lite_pkg::*;
    import tcb_lite_map_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS   = 16;   // words per target model
    localparam int N_PIPE      = 16;   // pipelined transfers
    // cycles of reset and of each test in order
    localparam int TEST_CYCLES = 3 + 12 + 2 + 3 + 4 + 5 + N_PIPE + 1;

    logic                   clk = 1'b0;
    logic                   reset = 1'b1;
    logic     [SUB_IFN-1:0] sub_vld;
    tcb_req_t [SUB_IFN-1:0] sub_req;
    logic     [SUB_IFN-1:0] sub_rdy;
    tcb_rsp_t [SUB_IFN-1:0] sub_rsp;
    logic     [MAN_IFN-1:0] man_vld;
    tcb_req_t [MAN_IFN-1:0] man_req;
    logic     [MAN_IFN-1:0] man_rdy;
    tcb_rsp_t [MAN_IFN-1:0] man_rsp = '0;

    int       stall_len [MAN_IFN];          // wait cycles before each target accepts
    int       stall_cnt [MAN_IFN] = '{0, 0};
    tcb_dat_t mem       [MAN_IFN][MEM_WORDS];
    tcb_dat_t exp_mem   [MAN_IFN][MEM_WORDS]; // expected contents
    string    test_name;

    // what access() saw
    logic     [MAN_IFN-1:0] obs_man_vld;
    tcb_req_t [MAN_IFN-1:0] obs_man_req;
    tcb_rsp_t               obs_early;      // sub_rsp in the transfer cycle
    tcb_rsp_t               obs_rsp;        // sub_rsp one cycle later
    int                     obs_waits;

    always #2 clk = ~clk;

    tcb_lite_interconnect i_dut (.*);

    // initial word from the full byte address
    function automatic tcb_dat_t fill_word(input tcb_adr_t adr);
        return {adr[15:0], adr[31:16]} ^ 32'h5a3c_c3a5;
    endfunction

    function automatic tcb_dat_t merge_bytes(input tcb_dat_t old, input tcb_dat_t wdt,
                                             input tcb_byt_t byt);
        tcb_dat_t res;
        res = old;
        for (int b = 0; b < BYT; b++) begin
            if (byt[b]) res[8*b +: 8] = wdt[8*b +: 8];
        end
        return res;
    endfunction

    ////////////////////////////////////////
    // target models
    ////////////////////////////////////////

    for (genvar m = 0; m < MAN_IFN; m++) begin: gen_rdy
        assign man_rdy[m] = stall_cnt[m] >= stall_len[m];
    end: gen_rdy

    always @(posedge clk) begin
        for (int m = 0; m < MAN_IFN; m++) begin
            if (reset) begin
                stall_cnt[m] <= 0;
                man_rsp[m]   <= '0;
                for (int w = 0; w < MEM_WORDS; w++) begin
                    mem[m][w] <= fill_word(MAN_BASE[m] + tcb_adr_t'(4*w));
                end
            end else begin
                man_rsp[m] <= '0;  // response lasts one cycle
                if (man_vld[m] && man_rdy[m]) begin
                    stall_cnt[m]   <= 0;
                    man_rsp[m].rdt <= mem[m][man_req[m].adr[5:2]];
                    if (man_req[m].wen) begin
                        mem[m][man_req[m].adr[5:2]] <= merge_bytes(
                            mem[m][man_req[m].adr[5:2]], man_req[m].wdt, man_req[m].byt);
                    end
                end else if (man_vld[m]) begin
                    stall_cnt[m] <= stall_cnt[m] + 1;  // count stalled cycles
                end
            end
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED [%s] %s: expected %0h, actual %0h", test_name, what, exp, act);
            $display("Checks failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    function automatic tcb_req_t make_req(input logic lck, input logic wen, input tcb_adr_t adr,
                                          input tcb_byt_t byt, input tcb_dat_t wdt);
        return '{lck: lck, wen: wen, ren: ~wen, adr: adr, byt: byt, wdt: wdt};
    endfunction

    // one transfer from sub s until rdy
    task automatic access(input int s, input tcb_req_t req);
        obs_waits = 0;
        next_cycle();
        sub_vld[s] = 1'b1;
        sub_req[s] = req;
        #1;
        while (!sub_rdy[s]) begin
            check("held vld", 1, |man_vld);
            check("held address", req.adr, man_req[0].adr);
            next_cycle();
            obs_waits++;
            #1;
        end
        obs_man_vld = man_vld;
        obs_man_req = man_req;
        obs_early   = sub_rsp[s];
        next_cycle();
        sub_vld[s] = 1'b0;
        sub_req[s] = '0;
        #1;
        obs_rsp = sub_rsp[s];
    endtask

    // write then read check at target m through sub s
    task automatic write_word(input int s, input int m, input int w, input tcb_byt_t byt,
                              input tcb_dat_t wdt);
        tcb_adr_t adr;
        adr = MAN_BASE[m] + tcb_adr_t'(4*w);
        access(s, make_req(1'b0, 1'b1, adr, byt, wdt));
        check("man_vld", 64'(2'b01 << m), obs_man_vld);
        check("man wen", 1, obs_man_req[m].wen);
        check("man adr", adr, obs_man_req[m].adr);
        check("man byt", byt, obs_man_req[m].byt);
        check("man wdt", wdt, obs_man_req[m].wdt);
        check("write err", 0, obs_rsp.err);
        exp_mem[m][w] = merge_bytes(exp_mem[m][w], wdt, byt);
    endtask

    task automatic read_word(input int s, input int m, input int w);
        access(s, make_req(1'b0, 1'b0, MAN_BASE[m] + tcb_adr_t'(4*w), '1, '0));
        check("man_vld", 64'(2'b01 << m), obs_man_vld);
        check("man ren", 1, obs_man_req[m].ren);
        check("no early rsp", 0, obs_early);
        check("read rdt", exp_mem[m][w], obs_rsp.rdt);
        check("read err", 0, obs_rsp.err);
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    task automatic test_write_read();
        test_name = "write_read";
        for (int m = 0; m < MAN_IFN; m++) begin
            write_word(m, m, 4, 4'hf, $urandom);
            write_word(m, m, 4, 4'b0101, $urandom);  // partial bytes
            read_word(m, m, 4);
        end
    endtask

    task automatic test_decode_miss();
        test_name = "decode_miss";
        access(1, make_req(1'b0, 1'b0, 32'h4000_0010, '1, '0));
        check("miss waits", 0, obs_waits);
        check("miss man_vld", 0, obs_man_vld);
        check("miss err", 1, obs_rsp.err);
        check("miss rdt", 0, obs_rsp.rdt);
    endtask

    task automatic test_priority();
        test_name = "priority";
        next_cycle();
        sub_vld    = 2'b11;
        sub_req[0] = make_req(1'b0, 1'b0, MAN_BASE[0] + 32'h4, '1, '0);
        sub_req[1] = make_req(1'b0, 1'b0, MAN_BASE[1] + 32'h8, '1, '0);
        #1;
        check("first grant", 2'b01, sub_rdy);
        next_cycle();
        sub_vld[0] = 1'b0;
        #1;
        check("second grant", 2'b10, sub_rdy);
        check("sub0 rdt", exp_mem[0][1], sub_rsp[0].rdt);
        next_cycle();
        sub_vld[1] = 1'b0;
        #1;
        check("sub1 rdt", exp_mem[1][2], sub_rsp[1].rdt);
    endtask

    task automatic test_lock();
        tcb_dat_t wdt;
        test_name = "lock";
        wdt = $urandom;
        next_cycle();
        sub_vld    = 2'b10;
        sub_req[1] = make_req(1'b1, 1'b1, MAN_BASE[0] + 32'h20, '1, wdt);  // locked write
        #1;
        check("lock grant", 2'b10, sub_rdy);
        exp_mem[0][8] = wdt;
        next_cycle();
        sub_vld    = 2'b11;
        sub_req[0] = make_req(1'b0, 1'b0, MAN_BASE[1] + 32'h20, '1, '0);
        sub_req[1] = make_req(1'b0, 1'b0, MAN_BASE[0] + 32'h20, '1, '0);
        #1;
        check("owner kept", 2'b10, sub_rdy);  // sub0 waits despite priority
        next_cycle();
        sub_vld[1] = 1'b0;
        #1;
        check("released", 2'b01, sub_rdy);
        check("owner rdt", wdt, sub_rsp[1].rdt);
        next_cycle();
        sub_vld[0] = 1'b0;
        #1;
        check("sub0 rdt", exp_mem[1][8], sub_rsp[0].rdt);
    endtask

    task automatic test_stall();
        test_name = "stall";
        stall_len[1] = 3;
        read_word(0, 1, 9);
        check("stall waits", 3, obs_waits);
        stall_len[1] = 0;
    endtask

    task automatic test_pipeline();
        tcb_dat_t exp_q [$];
        logic     rdt_q [$];
        tcb_req_t req;
        int       m;
        int       w;
        test_name = "pipeline";
        for (int k = 0; k <= N_PIPE; k++) begin
            next_cycle();
            if (k < N_PIPE) begin
                m   = k % 2;
                w   = $urandom % MEM_WORDS;
                req = make_req(1'b0, 1'($urandom), MAN_BASE[m] + tcb_adr_t'(4*w),
                               4'($urandom) | 4'b0001, $urandom);
                sub_vld[0] = 1'b1;
                sub_req[0] = req;
                exp_q.push_back(exp_mem[m][w]);
                rdt_q.push_back(~req.wen);
                if (req.wen) exp_mem[m][w] = merge_bytes(exp_mem[m][w], req.wdt, req.byt);
            end else begin
                sub_vld[0] = 1'b0;
            end
            #1;
            if (k < N_PIPE) check("pipe rdy", 1, sub_rdy[0]);
            if (k > 0) begin
                check("pipe err", 0, sub_rsp[0].err);
                if (rdt_q.pop_front()) begin
                    check("pipe rdt", exp_q[0], sub_rsp[0].rdt);
                end
                void'(exp_q.pop_front());
            end
        end
    endtask

    ////////////////////////////////////////
    // main
    ////////////////////////////////////////

    initial begin
        void'($urandom(32'hf48e_6bdb));
        sub_vld   = '0;
        sub_req   = '0;
        stall_len = '{0, 0};
        for (int m = 0; m < MAN_IFN; m++) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                exp_mem[m][w] = fill_word(MAN_BASE[m] + tcb_adr_t'(4*w));
            end
        end
        repeat (3) @(posedge clk);
        #0.5;
        reset = 1'b0;
        test_write_read();
        test_decode_miss();
        test_priority();
        test_lock();
        test_stall();
        test_pipeline();
        $display("All checks passed");
        $finish;
    end

    // watchdog at twice the summed test length
    initial begin
        #(2 * TEST_CYCLES * 4);
        $display("Checks failed");
        $fatal(1, "timeout: tests did not finish in time");
    end

endmodule: tcb_lite_interconnect_tb

// File: tcb_lite_interconnect.f
hw/tcb_lite_pkg.sv
hw/tcb_lite_map_pkg.sv
hw/tcb_lite_arbiter.sv
hw/tcb_lite_decoder.sv
hw/tcb_lite_switch.sv
hw/tcb_lite_interconnect.sv
sim/tcb_lite_interconnect_chk.sv
sim/tcb_lite_interconnect_tb.sv
